//--- verilog/alu_pkg.sv
`default_nettype none

package alu_pkg;

  //////////////////////////////
  // Widths
  //////////////////////////////

  // Operand and result width
  localparam int DATA_W = 16;

  // Shift distance that clears the whole word
  localparam int SHAMT_LIMIT = 16;

  // Bits needed to index a shift below the limit
  localparam int SHAMT_W = $clog2(SHAMT_LIMIT);

  //////////////////////////////
  // Opcodes
  //////////////////////////////

  // Values 12 to 15 are reserved and give a zero result
  typedef enum logic [3:0] {
    OP_SUB = 4'd0,
    OP_ADD = 4'd1,
    OP_OR  = 4'd2,
    OP_AND = 4'd3,
    OP_DEC = 4'd4,
    OP_INC = 4'd5,
    OP_INV = 4'd6,
    OP_SLA = 4'd7,
    OP_SRA = 4'd8,
    OP_SLL = 4'd9,
    OP_SRL = 4'd10,
    OP_SLE = 4'd11
  } alu_op_e;

  //////////////////////////////
  // Port handshake
  //////////////////////////////

  // Idle until an operation is taken, done until req is released
  typedef enum logic {
    PORT_IDLE = 1'b0,
    PORT_DONE = 1'b1
  } port_state_e;

  // Operation from the requester, 36 bits
  typedef struct packed {
    alu_op_e           op;
    logic [DATA_W-1:0] a;
    logic [DATA_W-1:0] b;
  } alu_req_t;

  // Result back to the requester, 18 bits
  typedef struct packed {
    logic [DATA_W-1:0] s;
    logic              overflow;
    logic              zero;
  } alu_rsp_t;

endpackage

`default_nettype wire

//--- verilog/alu_arith.sv
`timescale 1ns/1ps
`default_nettype none

module alu_arith (
  input  alu_pkg::alu_op_e             op,
  input  logic [alu_pkg::DATA_W-1:0]   a,
  input  logic [alu_pkg::DATA_W-1:0]   b,
  output logic [alu_pkg::DATA_W-1:0]   arith_s,
  output logic                         arith_ovf,
  output logic                         lte
);

  import alu_pkg::*;

  logic [DATA_W-1:0] opnd;
  logic              cin;
  logic [DATA_W-1:0] sum;
  logic              sign_a;
  logic              sign_b;
  logic              same_sign;
  logic              diff_zero;
  logic              ovf_raw;

  //////////////////////////////
  // Operand select
  //////////////////////////////

  // Subtract and compare take the two's complement of b
  always_comb begin
    case (op)
      OP_ADD: begin
        opnd = b;
        cin  = 1'b0;
      end
      OP_SUB, OP_SLE: begin
        opnd = ~b;
        cin  = 1'b1;
      end
      OP_INC: begin
        opnd = {{(DATA_W-1){1'b0}}, 1'b1};
        cin  = 1'b0;
      end
      OP_DEC: begin
        opnd = ~{{(DATA_W-1){1'b0}}, 1'b1};
        cin  = 1'b1;
      end
      default: begin
        opnd = b;
        cin  = 1'b0;
      end
    endcase
  end

  // The one shared adder
  assign sum = a + opnd + {{(DATA_W-1){1'b0}}, cin};

  assign arith_s = sum;

  //////////////////////////////
  // Flags
  //////////////////////////////

  // Same operand signs but the sum sign flipped
  assign ovf_raw = (a[DATA_W-1] == opnd[DATA_W-1]) && (sum[DATA_W-1] != a[DATA_W-1]);

  always_comb begin
    case (op)
      OP_ADD, OP_SUB, OP_INC, OP_DEC: arith_ovf = ovf_raw;
      default:                        arith_ovf = 1'b0;
    endcase
  end

  assign sign_a    = a[DATA_W-1];
  assign sign_b    = b[DATA_W-1];
  assign same_sign = (sign_a == sign_b);
  assign diff_zero = ~|sum;

  // Difference cannot overflow when the signs agree
  assign lte = (sign_a & ~sign_b) | (same_sign & (diff_zero | sum[DATA_W-1]));

endmodule

`default_nettype wire

//--- verilog/alu_bitwise.sv
`timescale 1ns/1ps
`default_nettype none

module alu_bitwise (
  input  alu_pkg::alu_op_e             op,
  input  logic [alu_pkg::DATA_W-1:0]   a,
  input  logic [alu_pkg::DATA_W-1:0]   b,
  output logic [alu_pkg::DATA_W-1:0]   bitwise_s
);

  import alu_pkg::*;

  logic [SHAMT_W-1:0] shamt;
  logic               shift_out;
  logic [DATA_W-1:0]  sign_fill;
  logic [DATA_W-1:0]  shl;
  logic [DATA_W-1:0]  shr_log;
  logic [DATA_W-1:0]  shr_ari;

  //////////////////////////////
  // Shifters
  //////////////////////////////

  // Distance is the unsigned b
  assign shift_out = (b >= DATA_W'(SHAMT_LIMIT));
  assign shamt     = b[SHAMT_W-1:0];

  // Every bit is a copy of the sign
  assign sign_fill = {DATA_W{a[DATA_W-1]}};

  // Left shifts fill with zeros, arithmetic and logical alike
  assign shl = shift_out ? '0 : (a << shamt);

  assign shr_log = shift_out ? '0 : (a >> shamt);

  assign shr_ari = shift_out ? sign_fill : DATA_W'($signed(a) >>> shamt);

  //////////////////////////////
  // Logic ops
  //////////////////////////////

  always_comb begin
    case (op)
      OP_AND:         bitwise_s = a & b;
      OP_OR:          bitwise_s = a | b;
      OP_INV:         bitwise_s = ~a;
      OP_SLA, OP_SLL: bitwise_s = shl;
      OP_SRA:         bitwise_s = shr_ari;
      OP_SRL:         bitwise_s = shr_log;
      // Not a bitwise op
      default:        bitwise_s = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- verilog/alu_result_select.sv
`timescale 1ns/1ps
`default_nettype none

module alu_result_select (
  input  alu_pkg::alu_op_e             op,
  input  logic [alu_pkg::DATA_W-1:0]   arith_s,
  input  logic [alu_pkg::DATA_W-1:0]   bitwise_s,
  input  logic                         arith_ovf,
  input  logic                         lte,
  output alu_pkg::alu_rsp_t            next_rsp
);

  import alu_pkg::*;

  logic [DATA_W-1:0] word;
  logic              ovf;

  //////////////////////////////
  // Word select
  //////////////////////////////

  always_comb begin
    case (op)
      OP_SUB, OP_ADD, OP_DEC, OP_INC: word = arith_s;
      OP_OR, OP_AND, OP_INV:          word = bitwise_s;
      OP_SLA, OP_SRA, OP_SLL, OP_SRL: word = bitwise_s;
      // Compare result sits in bit 0
      OP_SLE:                         word = {{(DATA_W-1){1'b0}}, lte};
      // Reserved opcodes
      default:                        word = '0;
    endcase
  end

  // Overflow only means something for the adder ops
  always_comb begin
    case (op)
      OP_SUB, OP_ADD, OP_DEC, OP_INC: ovf = arith_ovf;
      default:                        ovf = 1'b0;
    endcase
  end

  //////////////////////////////
  // Response
  //////////////////////////////

  always_comb begin
    next_rsp          = '0;
    next_rsp.s        = word;
    next_rsp.overflow = ovf;
    next_rsp.zero     = ~|word;
  end

endmodule

`default_nettype wire

//--- verilog/alu_port.sv
`timescale 1ns/1ps
`default_nettype none

module alu_port (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 req,
  input  alu_pkg::alu_req_t    req_data,
  input  alu_pkg::alu_rsp_t    next_rsp,
  output alu_pkg::alu_req_t    op_q,
  output logic                 ack,
  output alu_pkg::alu_rsp_t    rsp
);

  import alu_pkg::*;

  port_state_e state_q;
  logic        accept;

  // Only one operation in flight
  assign accept = (state_q == PORT_IDLE) && req;

  //////////////////////////////
  // Handshake FSM
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= PORT_IDLE;
      ack     <= 1'b0;
      rsp     <= '0;
    end else begin
      case (state_q)
        PORT_IDLE: begin
          if (accept) begin
            state_q <= PORT_DONE;
          end
        end
        PORT_DONE: begin
          if (!ack) begin
            // Datapath has settled on op_q by now
            ack <= 1'b1;
            rsp <= next_rsp;
          end else if (!req) begin
            ack     <= 1'b0;
            state_q <= PORT_IDLE;
          end
        end
      endcase
    end
  end

  // Operation capture
  always_ff @(posedge clk) begin
    if (accept) begin
      op_q <= req_data;
    end
  end

endmodule

`default_nettype wire

//--- verilog/alu_control.sv
`timescale 1ns/1ps
`default_nettype none

module alu_control (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 req,
  input  alu_pkg::alu_req_t    req_data,
  output logic                 ack,
  output alu_pkg::alu_rsp_t    rsp
);

  import alu_pkg::*;

  alu_req_t          op_q;
  alu_rsp_t          next_rsp;
  logic [DATA_W-1:0] arith_s;
  logic [DATA_W-1:0] bitwise_s;
  logic              arith_ovf;
  logic              lte;

  //////////////////////////////
  // Request port
  //////////////////////////////

  alu_port u_port (
    .clk      (clk),
    .rst_n    (rst_n),
    .req      (req),
    .req_data (req_data),
    .next_rsp (next_rsp),
    .op_q     (op_q),
    .ack      (ack),
    .rsp      (rsp)
  );

  //////////////////////////////
  // Datapath
  //////////////////////////////

  alu_arith u_arith (
    .op        (op_q.op),
    .a         (op_q.a),
    .b         (op_q.b),
    .arith_s   (arith_s),
    .arith_ovf (arith_ovf),
    .lte       (lte)
  );

  alu_bitwise u_bitwise (
    .op        (op_q.op),
    .a         (op_q.a),
    .b         (op_q.b),
    .bitwise_s (bitwise_s)
  );

  alu_result_select u_select (
    .op        (op_q.op),
    .arith_s   (arith_s),
    .bitwise_s (bitwise_s),
    .arith_ovf (arith_ovf),
    .lte       (lte),
    .next_rsp  (next_rsp)
  );

endmodule

`default_nettype wire

//--- sim/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
  output logic clk,
  output logic rst_n
);

  // 40 ns period
  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Reset held for 4 cycles, released on a falling edge
  initial begin
    rst_n = 1'b0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

`default_nettype wire

//--- sim/alu_port_properties.sv
`timescale 1ns/1ps
`default_nettype none

module alu_port_properties (
  input logic                  clk,
  input logic                  rst_n,
  input logic                  req,
  input alu_pkg::alu_req_t     req_data,
  input alu_pkg::port_state_e  state_q,
  input logic                  ack,
  input alu_pkg::alu_rsp_t     rsp
);

  import alu_pkg::*;

  //////////////////////////////
  // Requester side
  //////////////////////////////

  // Operation held until ack
  a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
    req && $past(req) && !ack |-> $stable(req_data))
    else $error("req_data changed while waiting for ack");

  //////////////////////////////
  // DUT side
  //////////////////////////////

  a_idle_no_ack: assert property (@(posedge clk) disable iff (!rst_n)
    state_q == PORT_IDLE |-> !ack)
    else $error("ack high in idle state");

  // Response frozen for the whole ack phase
  a_rsp_stable: assert property (@(posedge clk) disable iff (!rst_n)
    ack && $past(ack) |-> $stable(rsp))
    else $error("rsp changed while ack high");

  a_ack_after_req: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(ack) |-> !$past(req))
    else $error("ack dropped while req still high");

endmodule

bind alu_port alu_port_properties u_port_props (
  .clk      (clk),
  .rst_n    (rst_n),
  .req      (req),
  .req_data (req_data),
  .state_q  (state_q),
  .ack      (ack),
  .rsp      (rsp)
);

`default_nettype wire

//--- sim/tb_alu_control.sv
`timescale 1ns/1ps
`default_nettype none

module tb_alu_control;

  import alu_pkg::*;

  logic     clk;
  logic     rst_n;
  logic     req;
  alu_req_t req_data;
  logic     ack;
  alu_rsp_t rsp;
  int       seed;

  tb_clock u_clock (
    .clk   (clk),
    .rst_n (rst_n)
  );

  alu_control u_dut (
    .clk      (clk),
    .rst_n    (rst_n),
    .req      (req),
    .req_data (req_data),
    .ack      (ack),
    .rsp      (rsp)
  );

  //////////////////////////////
  // Reference model
  //////////////////////////////

  function automatic alu_rsp_t model(input logic [3:0] op, input logic [15:0] a,
                                     input logic [15:0] b);
    int       sa;
    int       sb;
    int       sh;
    int       r;
    logic     arith;
    alu_rsp_t m;
    sa = {{16{a[15]}}, a};
    sb = {{16{b[15]}}, b};
    sh = {16'h0, b};
    m  = '0;
    r  = 0;
    arith = (op == OP_SUB) || (op == OP_ADD) || (op == OP_DEC) || (op == OP_INC);
    case (op)
      OP_SUB: r = sa - sb;
      OP_ADD: r = sa + sb;
      OP_DEC: r = sa - 1;
      OP_INC: r = sa + 1;
      default: r = 0;
    endcase
    case (op)
      OP_SUB, OP_ADD, OP_DEC, OP_INC: m.s = r[15:0];
      OP_OR:  m.s = a | b;
      OP_AND: m.s = a & b;
      OP_INV: m.s = ~a;
      OP_SLA, OP_SLL: begin
        if (sh >= 16) m.s = 16'h0;
        else m.s = a << sh;
      end
      OP_SRL: begin
        if (sh >= 16) m.s = 16'h0;
        else m.s = a >> sh;
      end
      OP_SRA: begin
        if (sh >= 16) m.s = {16{a[15]}};
        else m.s = $signed(a) >>> sh;
      end
      OP_SLE: m.s = (sa <= sb) ? 16'd1 : 16'd0;
      default: m.s = 16'h0;
    endcase
    // Signed result outside the 16-bit range
    m.overflow = arith && ((r > 32767) || (r < -32768));
    m.zero     = (m.s == 16'h0);
    return m;
  endfunction

  function automatic logic [15:0] rand_word();
    logic [31:0] rnd;
    rnd = $random(seed);
    return rnd[15:0];
  endfunction

  //////////////////////////////
  // Checks and handshake
  //////////////////////////////

  task automatic check_equal(input string what, input logic [15:0] expected,
                             input logic [15:0] actual);
    if (actual !== expected) begin
      $display("FAIL %0t ns: %s expected %h got %h", $time, what, expected, actual);
      $display("SOME TESTS FAILED");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  // Polls ack on falling edges, 20 cycles at most
  task automatic wait_ack(input logic level, input string what);
    int n;
    n = 0;
    while (ack !== level && n < 20) begin
      @(negedge clk);
      n++;
    end
    if (ack !== level) begin
      $display("Timeout: %s", what);
      $display("SOME TESTS FAILED");
      $fatal(1, "handshake timed out");
    end
  endtask

  task automatic wait_reset();
    int n;
    n = 0;
    while (rst_n !== 1'b1 && n < 20) begin
      @(negedge clk);
      n++;
    end
    if (rst_n !== 1'b1) begin
      $display("Timeout: reset was never released");
      $display("SOME TESTS FAILED");
      $fatal(1, "reset timed out");
    end
  endtask

  task automatic do_op(input logic [3:0] op, input logic [15:0] a, input logic [15:0] b,
                       output alu_rsp_t got);
    @(negedge clk);
    req_data = {op, a, b};
    req      = 1'b1;
    wait_ack(1'b1, "ack did not rise");
    got = rsp;
    req = 1'b0;
    wait_ack(1'b0, "ack did not fall after req dropped");
  endtask

  task automatic run_check(input logic [3:0] op, input logic [15:0] a, input logic [15:0] b);
    alu_rsp_t got;
    alu_rsp_t exp;
    string    tag;
    do_op(op, a, b, got);
    exp = model(op, a, b);
    tag = $sformatf("op %0d a %h b %h", op, a, b);
    check_equal({tag, " result"}, exp.s, got.s);
    check_equal({tag, " overflow"}, 16'(exp.overflow), 16'(got.overflow));
    check_equal({tag, " zero"}, 16'(exp.zero), 16'(got.zero));
  endtask

  // Hand-computed expectation, zero flag follows from the result
  task automatic run_expect(input logic [3:0] op, input logic [15:0] a, input logic [15:0] b,
                            input logic [15:0] exp_s, input logic exp_ovf);
    alu_rsp_t got;
    string    tag;
    do_op(op, a, b, got);
    tag = $sformatf("op %0d a %h b %h", op, a, b);
    check_equal({tag, " result"}, exp_s, got.s);
    check_equal({tag, " overflow"}, 16'(exp_ovf), 16'(got.overflow));
    check_equal({tag, " zero"}, 16'(exp_s == 16'h0), 16'(got.zero));
  endtask

  //////////////////////////////
  // Directed tests
  //////////////////////////////

  task automatic test_arith();
    // Signed overflow corners
    run_expect(OP_ADD, 16'h7fff, 16'h0001, 16'h8000, 1'b1);
    run_expect(OP_SUB, 16'h8000, 16'h0001, 16'h7fff, 1'b1);
    run_expect(OP_DEC, 16'h8000, 16'h0000, 16'h7fff, 1'b1);
    run_expect(OP_INC, 16'h7fff, 16'h0000, 16'h8000, 1'b1);
    run_expect(OP_ADD, 16'h8000, 16'h8000, 16'h0000, 1'b1);
    run_expect(OP_ADD, 16'hffff, 16'h0001, 16'h0000, 1'b0);
    run_expect(OP_SUB, 16'h0000, 16'h0001, 16'hffff, 1'b0);
    run_expect(OP_INC, 16'hffff, 16'h1234, 16'h0000, 1'b0);
    run_expect(OP_DEC, 16'h0000, 16'h0000, 16'hffff, 1'b0);
    for (int i = 0; i < 8; i++) begin
      run_check(OP_SUB, rand_word(), rand_word());
      run_check(OP_ADD, rand_word(), rand_word());
      run_check(OP_DEC, rand_word(), rand_word());
      run_check(OP_INC, rand_word(), rand_word());
    end
  endtask

  task automatic test_logic();
    run_expect(OP_AND, 16'hf0f0, 16'h3c3c, 16'h3030, 1'b0);
    run_expect(OP_OR,  16'hf0f0, 16'h3c3c, 16'hfcfc, 1'b0);
    run_expect(OP_INV, 16'h00ff, 16'h1234, 16'hff00, 1'b0);
    for (int i = 0; i < 6; i++) begin
      run_check(OP_AND, rand_word(), rand_word());
      run_check(OP_OR,  rand_word(), rand_word());
      run_check(OP_INV, rand_word(), rand_word());
    end
  endtask

  task automatic test_shifts();
    logic [15:0] amounts [5];
    logic [15:0] a;
    amounts = '{16'd0, 16'd1, 16'd15, 16'd16, 16'hff00};
    for (int i = 0; i < 5; i++) begin
      a = rand_word();
      run_check(OP_SLA, a, amounts[i]);
      run_check(OP_SLL, a, amounts[i]);
      run_check(OP_SRL, a, amounts[i]);
      run_check(OP_SRA, a, amounts[i]);
      // Negative a for sign fill
      run_check(OP_SRA, 16'h8421, amounts[i]);
    end
    run_expect(OP_SRA, 16'h8000, 16'd16, 16'hffff, 1'b0);
    run_expect(OP_SRA, 16'h8000, 16'd15, 16'hffff, 1'b0);
    run_expect(OP_SRL, 16'h8000, 16'd15, 16'h0001, 1'b0);
    run_expect(OP_SLA, 16'h0001, 16'd15, 16'h8000, 1'b0);
    run_expect(OP_SLL, 16'hffff, 16'h0100, 16'h0000, 1'b0);
  endtask

  task automatic test_sle();
    run_expect(OP_SLE, 16'h0005, 16'h0005, 16'h0001, 1'b0);
    run_expect(OP_SLE, 16'hffff, 16'h0001, 16'h0001, 1'b0);
    run_expect(OP_SLE, 16'h0001, 16'hffff, 16'h0000, 1'b0);
    run_expect(OP_SLE, 16'h7fff, 16'h8000, 16'h0000, 1'b0);
    run_expect(OP_SLE, 16'h8000, 16'h7fff, 16'h0001, 1'b0);
    run_expect(OP_SLE, 16'h0004, 16'h0005, 16'h0001, 1'b0);
    run_expect(OP_SLE, 16'h0005, 16'h0004, 16'h0000, 1'b0);
    run_expect(OP_SLE, 16'h8000, 16'h8001, 16'h0001, 1'b0);
    for (int i = 0; i < 4; i++) begin
      run_check(OP_SLE, rand_word(), rand_word());
    end
  endtask

  task automatic test_zero_reserved();
    logic [15:0] a;
    a = rand_word();
    run_expect(OP_SUB, a, a, 16'h0000, 1'b0);
    run_expect(OP_AND, 16'h00ff, 16'hff00, 16'h0000, 1'b0);
    for (int k = 12; k < 16; k++) begin
      run_expect(4'(k), rand_word(), rand_word(), 16'h0000, 1'b0);
    end
  endtask

  task automatic test_backpressure();
    alu_rsp_t held;
    @(negedge clk);
    req_data = {OP_ADD, 16'h1234, 16'h4321};
    req      = 1'b1;
    wait_ack(1'b1, "ack did not rise under back-pressure");
    held = rsp;
    check_equal("held result", 16'h5555, held.s);
    check_equal("held overflow", 16'h0000, 16'(held.overflow));
    check_equal("held zero", 16'h0000, 16'(held.zero));
    // Requester keeps req high for 10 cycles
    for (int i = 0; i < 10; i++) begin
      @(negedge clk);
      check_equal("ack held high", 16'h0001, 16'(ack));
      check_equal("rsp word held", held.s, rsp.s);
      check_equal("rsp flags held", {14'h0, held.overflow, held.zero},
                  {14'h0, rsp.overflow, rsp.zero});
    end
    req = 1'b0;
    wait_ack(1'b0, "ack did not fall after back-pressure");
    run_expect(OP_SUB, 16'h0100, 16'h0001, 16'h00ff, 1'b0);
  endtask

  initial begin
    req      = 1'b0;
    req_data = '0;
    seed     = 32'h4463bffc;
    wait_reset();
    check_equal("ack after reset", 16'h0000, 16'(ack));
    check_equal("rsp after reset", 16'h0000, rsp.s);
    check_equal("rsp flags after reset", 16'h0000, {14'h0, rsp.overflow, rsp.zero});
    test_arith();
    test_logic();
    test_shifts();
    test_sle();
    test_zero_reserved();
    test_backpressure();
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- alu_control.f
verilog/alu_pkg.sv
verilog/alu_arith.sv
verilog/alu_bitwise.sv
verilog/alu_result_select.sv
verilog/alu_port.sv
verilog/alu_control.sv
sim/tb_clock.sv
sim/alu_port_properties.sv
sim/tb_alu_control.sv

//--- Makefile
TOP := tb_alu_control

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f alu_control.f --top-module $(TOP) -o $(TOP)
	@out=$$(./obj_dir/$(TOP)); echo "$$out"; echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir
